//--- Bender.yml
package:
  name: dram_port

sources:
  # Package first, then the stage interface
  - hdl/dram_pkg.sv
  - hdl/dram_xfer_if.sv

  # Stages and top level
  - hdl/dram_cmd_decode.sv
  - hdl/dram_xfer_engine.sv
  - hdl/dram_bus_result.sv
  - hdl/dram_port_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/dram_port_tb.sv

//--- filelist.f
hdl/dram_pkg.sv
hdl/dram_xfer_if.sv
hdl/dram_cmd_decode.sv
hdl/dram_xfer_engine.sv
hdl/dram_bus_result.sv
hdl/dram_port_top.sv
sim/dram_port_tb.sv

//--- hdl/dram_bus_result.sv
`timescale 1ns/1ps

module dram_bus_result (
    input  logic        cmd_vld,
    input  logic        dat_oe,
    dram_xfer_if.result xf,
    output logic        in_rdy,
    output logic        out_vld
);

    // Phase decode
    logic cmd_phase;
    logic from_phase;
    logic to_phase;

    assign cmd_phase  = (xf.state == dram_pkg::CMD);
    assign from_phase = (xf.state == dram_pkg::FROM_CHIP);
    assign to_phase   = (xf.state == dram_pkg::TO_CHIP);

    // ====================
    // Inbound ready
    // ====================

    // Only while the chip drives the bus
    // Command phase takes the word that comes with cmd_vld
    // Write phase takes data until cmd_vld closes the transfer
    always_comb begin
        in_rdy = 1'b0;
        if (dat_oe) begin
            if (cmd_phase && cmd_vld) begin
                in_rdy = 1'b1;
            end else if (from_phase && !cmd_vld) begin
                in_rdy = 1'b1;
            end
        end
    end

    // ====================
    // Outbound valid
    // ====================

    // Memory offers a word for the whole read phase
    // Dropped in the closing cycle so valid and ready alone mark a beat
    always_comb begin
        out_vld = 1'b0;
        if (to_phase && !cmd_vld) begin
            out_vld = 1'b1;
        end
    end

endmodule

//--- hdl/dram_cmd_decode.sv
`timescale 1ns/1ps

module dram_cmd_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_vld,
    input  logic                dat_oe,
    input  dram_pkg::bus_word_u in_dat,
    input  logic                in_vld,
    input  logic                in_rdy,
    dram_xfer_if.decoder        xf
);

    // Command accepted on the bus this cycle
    logic                        take;
    // Chip opens a new command sequence from idle
    logic                        open_win;
    // Last accepted command
    logic                        dir_q;
    logic [dram_pkg::ADDR_W-1:0] addr_q;

    // ====================
    // Command detect
    // ====================

    // Any accepted beat in the command phase is a command word
    // in_rdy already carries the cmd_vld and dat_oe qualifiers
    assign take = (xf.state == dram_pkg::CMD) && in_vld && in_rdy;

    // Start of a new command sequence
    assign open_win = (xf.state == dram_pkg::IDLE) && cmd_vld && dat_oe;

    // ====================
    // Command hold
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dir_q  <= 1'b0;
            addr_q <= '0;
        end else if (take) begin
            // Split the word through the command view
            dir_q  <= in_dat.cmd.dir;
            addr_q <= in_dat.cmd.addr;
        end else if (open_win) begin
            // Drop the stale command once a new one is announced
            dir_q  <= 1'b0;
            addr_q <= '0;
        end
    end

    // Live fields in the take cycle so the engine loads on the next edge
    // Held fields otherwise
    assign xf.cmd_take = take;
    assign xf.cmd_dir  = take ? in_dat.cmd.dir : dir_q;
    assign xf.cmd_addr = take ? in_dat.cmd.addr : addr_q;

endmodule

//--- hdl/dram_pkg.sv
package dram_pkg;

    // ====================
    // Bus and storage sizes
    // ====================

    // Shared data bus between chip and memory
    localparam int BUS_W = 128;

    // Start address field of a command word
    localparam int ADDR_W = 32;

    // On-die word array depth
    localparam int MEM_DEPTH = 1024;

    // Array index width, low address bits only
    localparam int IDX_W = $clog2(MEM_DEPTH);

    // Unused upper part of a command word
    localparam int RSVD_W = BUS_W - ADDR_W - 1;

    // Direction bit value for chip-to-memory transfers
    // Zero moves data into the chip
    localparam logic DIR_FROM_CHIP = 1'b1;

    // ====================
    // Port phases
    // ====================

    // Port FSM encoding
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        CMD       = 2'd1,
        TO_CHIP   = 2'd2,
        FROM_CHIP = 2'd3
    } port_state_e;

    // ====================
    // Bus word views
    // ====================

    // Command layout on the inbound bus
    // Direction in bit 0, address right above it
    typedef struct packed {
        logic [RSVD_W-1:0] rsvd;
        logic [ADDR_W-1:0] addr;
        logic              dir;
    } cmd_word_t;

    // Same inbound word seen as a command or as a data beat
    typedef union packed {
        cmd_word_t         cmd;
        logic [BUS_W-1:0]  data;
    } bus_word_u;

endpackage

//--- hdl/dram_port_top.sv
`timescale 1ns/1ps

module dram_port_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // Chip-side control
    input  logic                       cmd_vld,
    input  logic                       dat_oe,
    // Inbound half of the data bus
    input  logic [dram_pkg::BUS_W-1:0] in_dat,
    input  logic                       in_vld,
    output logic                       in_rdy,
    // Outbound half of the data bus
    output logic [dram_pkg::BUS_W-1:0] out_dat,
    output logic                       out_vld,
    input  logic                       out_rdy
);

    // ====================
    // Stage links
    // ====================

    // Command and phase between the three stages
    dram_xfer_if i_xfer_if ();

    // ====================
    // Stages
    // ====================

    // Decode, catch and split the command word
    dram_cmd_decode i_cmd_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .dat_oe  (dat_oe),
        .in_dat  (in_dat),
        .in_vld  (in_vld),
        .in_rdy  (in_rdy),
        .xf      (i_xfer_if.decoder)
    );

    // Execute, FSM plus address counter plus storage
    dram_xfer_engine i_xfer_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .dat_oe  (dat_oe),
        .in_dat  (in_dat),
        .in_vld  (in_vld),
        .in_rdy  (in_rdy),
        .out_rdy (out_rdy),
        .out_dat (out_dat),
        .xf      (i_xfer_if.engine)
    );

    // Result, bus handshake levels
    // Its in_rdy also feeds decode and execute
    dram_bus_result i_bus_result (
        .cmd_vld (cmd_vld),
        .dat_oe  (dat_oe),
        .xf      (i_xfer_if.result),
        .in_rdy  (in_rdy),
        .out_vld (out_vld)
    );

endmodule

//--- hdl/dram_xfer_engine.sv
`timescale 1ns/1ps

module dram_xfer_engine (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_vld,
    input  logic                       dat_oe,
    input  dram_pkg::bus_word_u        in_dat,
    input  logic                       in_vld,
    input  logic                       in_rdy,
    input  logic                       out_rdy,
    output logic [dram_pkg::BUS_W-1:0] out_dat,
    dram_xfer_if.engine                xf
);

    // Port FSM
    dram_pkg::port_state_e      state_q;
    dram_pkg::port_state_e      state_d;

    // Current word index, wraps at MEM_DEPTH
    logic [dram_pkg::IDX_W-1:0] addr_q;

    // Accepted beats per direction
    logic                       to_beat;
    logic                       from_beat;

    // On-die word array
    logic [dram_pkg::BUS_W-1:0] mem [dram_pkg::MEM_DEPTH];

    // ====================
    // Beat detect
    // ====================

    // Outbound beat while the chip keeps cmd_vld low
    // The closing cmd_vld cycle never counts
    assign to_beat = (state_q == dram_pkg::TO_CHIP) && !cmd_vld && out_rdy;

    // Inbound beat on the shared ready from the result stage
    assign from_beat = (state_q == dram_pkg::FROM_CHIP) && in_vld && in_rdy;

    assign xf.beat = to_beat || from_beat;

    // ====================
    // Port FSM
    // ====================

    always_comb begin
        state_d = state_q;
        case (state_q)
            dram_pkg::IDLE: begin
                // Command announce, only while the chip owns the bus
                if (cmd_vld && dat_oe) begin
                    state_d = dram_pkg::CMD;
                end
            end
            dram_pkg::CMD: begin
                // Wait for the command word itself
                if (xf.cmd_take) begin
                    if (xf.cmd_dir == dram_pkg::DIR_FROM_CHIP) begin
                        state_d = dram_pkg::FROM_CHIP;
                    end else begin
                        state_d = dram_pkg::TO_CHIP;
                    end
                end
            end
            dram_pkg::TO_CHIP,
            dram_pkg::FROM_CHIP: begin
                // Chip closes the transfer by raising cmd_vld again
                if (cmd_vld) begin
                    state_d = dram_pkg::IDLE;
                end
            end
            default: begin
                state_d = dram_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dram_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign xf.state = state_q;

    // ====================
    // Address counter
    // ====================

    // Load on command, step on every accepted beat
    // Upper address bits fall away, so a long burst wraps to word 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (xf.cmd_take) begin
            addr_q <= xf.cmd_addr[dram_pkg::IDX_W-1:0];
        end else if (xf.beat) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // ====================
    // Word array
    // ====================

    // Inbound beats land at the current index
    always_ff @(posedge clk) begin
        if (from_beat) begin
            mem[addr_q] <= in_dat.data;
        end
    end

    // Outbound word follows the index with no added latency
    // Stalled index keeps the word steady
    assign out_dat = mem[addr_q];

endmodule

//--- hdl/dram_xfer_if.sv
`timescale 1ns/1ps

interface dram_xfer_if;

    // Command accepted this cycle
    logic                        cmd_take;

    // Direction of the latest command
    logic                        cmd_dir;

    // Start address of the latest command
    logic [dram_pkg::ADDR_W-1:0] cmd_addr;

    // Current port phase
    dram_pkg::port_state_e       state;

    // Data beat accepted this cycle, either direction
    logic                        beat;

    // Command capture side
    modport decoder (
        output cmd_take,
        output cmd_dir,
        output cmd_addr,
        input  state
    );

    // FSM, address counter and storage
    modport engine (
        input  cmd_take,
        input  cmd_dir,
        input  cmd_addr,
        output state,
        output beat
    );

    // Bus handshake policy
    modport result (
        input  state
    );

endinterface

//--- sim/dram_port_tb.sv
`timescale 1ns/1ps

module dram_port_tb;

    // ====================
    // Run sizes
    // ====================

    localparam int N_XFER     = 40;
    localparam int MAX_LEN    = 16;
    localparam int GAP_CYC    = 4;
    localparam int XFER_OVH   = 10;
    localparam int RESET_CYC  = 10;
    // Directed transfers after the random ones
    localparam int N_DIRECTED = 4;
    localparam int TIMEOUT_CYC = (N_XFER + N_DIRECTED) * (MAX_LEN * GAP_CYC + XFER_OVH)
                                 + RESET_CYC + 50;

    // DUT ports
    logic                       clk;
    logic                       rst_n;
    logic                       cmd_vld;
    logic                       dat_oe;
    logic [dram_pkg::BUS_W-1:0] in_dat;
    logic                       in_vld;
    logic                       in_rdy;
    logic [dram_pkg::BUS_W-1:0] out_dat;
    logic                       out_vld;
    logic                       out_rdy;

    // Memory model of the words the chip has written
    logic [dram_pkg::BUS_W-1:0] model [int];
    // Word index the DUT should be at
    int                         cur_idx;
    int                         errors;
    int                         checks;
    int                         cycle_cnt;

    dram_port_top i_dram_port_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .dat_oe  (dat_oe),
        .in_dat  (in_dat),
        .in_vld  (in_vld),
        .in_rdy  (in_rdy),
        .out_dat (out_dat),
        .out_vld (out_vld),
        .out_rdy (out_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: port stopped responding after %0d cycles", cycle_cnt);
            $display("Errors: %0d, checks: %0d", errors, checks);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================

    function automatic logic [dram_pkg::BUS_W-1:0] rand_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Direction in bit 0, address in bits 32:1, rest zero
    function automatic logic [dram_pkg::BUS_W-1:0] make_cmd(input logic dir,
                                                             input logic [31:0] addr);
        logic [dram_pkg::BUS_W-1:0] w;
        w       = '0;
        w[0]    = dir;
        w[32:1] = addr;
        return w;
    endfunction

    // Port must be quiet outside a transfer
    task automatic check_idle(input string where);
        checks++;
        if (in_rdy || out_vld) begin
            errors++;
            $display("ERR %0t: %s in_rdy=%b out_vld=%b, expected both low",
                     $time, where, in_rdy, out_vld);
        end
    endtask

    // Announce, then send the command word
    task automatic start_cmd(input logic dir, input logic [31:0] addr);
        @(posedge clk);
        dat_oe  <= 1'b1;
        cmd_vld <= 1'b1;
        in_vld  <= 1'b0;
        out_rdy <= 1'b0;
        @(negedge clk);
        check_idle("announce");
        @(posedge clk);
        in_vld <= 1'b1;
        in_dat <= make_cmd(dir, addr);
        @(negedge clk);
        checks++;
        if (!in_rdy) begin
            errors++;
            $display("ERR %0t: in_rdy low in command phase", $time);
        end
        cur_idx = addr % dram_pkg::MEM_DEPTH;
    endtask

    task automatic write_burst(input int len);
        int n;
        n = 0;
        while (n < len) begin
            @(posedge clk);
            cmd_vld <= 1'b0;
            in_vld  <= ($urandom_range(0, 3) != 0);
            in_dat  <= rand_word();
            @(negedge clk);
            checks++;
            if (!in_rdy) begin
                errors++;
                $display("ERR %0t: in_rdy low in write phase", $time);
            end
            if (in_vld && in_rdy) begin
                model[cur_idx] = in_dat;
                cur_idx = (cur_idx + 1) % dram_pkg::MEM_DEPTH;
                n++;
            end
        end
    endtask

    task automatic read_burst(input int len);
        int                         n;
        logic                       stalled;
        logic [dram_pkg::BUS_W-1:0] held;
        n       = 0;
        stalled = 1'b0;
        held    = '0;
        while (n < len) begin
            @(posedge clk);
            cmd_vld <= 1'b0;
            in_vld  <= 1'b0;
            out_rdy <= ($urandom_range(0, 3) != 0);
            @(negedge clk);
            checks++;
            if (!out_vld) begin
                errors++;
                $display("ERR %0t: out_vld low in read phase", $time);
            end
            // Word must not move while the chip stalls
            if (stalled && (out_dat !== held)) begin
                errors++;
                $display("ERR %0t: out_dat changed during stall at word %0d",
                         $time, cur_idx);
            end
            if (out_vld && out_rdy) begin
                if (model.exists(cur_idx)) begin
                    checks++;
                    if (out_dat !== model[cur_idx]) begin
                        errors++;
                        $display("ERR %0t: word %0d read %h, expected %h",
                                 $time, cur_idx, out_dat, model[cur_idx]);
                    end
                end
                cur_idx = (cur_idx + 1) % dram_pkg::MEM_DEPTH;
                n++;
                stalled = 1'b0;
            end else begin
                stalled = 1'b1;
                held    = out_dat;
            end
        end
    endtask

    // cmd_vld ends the transfer and one quiet cycle follows
    task automatic close_xfer();
        @(posedge clk);
        cmd_vld <= 1'b1;
        in_vld  <= 1'b0;
        out_rdy <= 1'b0;
        @(posedge clk);
        cmd_vld <= 1'b0;
        @(negedge clk);
        check_idle("after close");
    endtask

    // Full write sequence with the bus not owned by the chip
    task automatic ignored_write(input logic [31:0] addr);
        @(posedge clk);
        dat_oe  <= 1'b0;
        cmd_vld <= 1'b1;
        in_vld  <= 1'b0;
        @(negedge clk);
        check_idle("dat_oe low announce");
        // Command word with cmd_vld still high
        @(posedge clk);
        in_vld <= 1'b1;
        in_dat <= make_cmd(1'b1, addr);
        repeat (6) begin
            @(negedge clk);
            check_idle("dat_oe low");
            @(posedge clk);
            cmd_vld <= 1'b0;
            in_dat  <= rand_word();
        end
        @(negedge clk);
        check_idle("dat_oe low");
        // Closing cmd_vld, still without the bus
        @(posedge clk);
        cmd_vld <= 1'b1;
        in_vld  <= 1'b0;
        @(posedge clk);
        cmd_vld <= 1'b0;
        dat_oe  <= 1'b1;
        @(negedge clk);
        check_idle("dat_oe restored");
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int          seed_val;
        logic        dir;
        logic [31:0] addr;
        int          len;
        seed_val  = $urandom(65);
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;
        cur_idx   = 0;
        rst_n     = 1'b0;
        cmd_vld   = 1'b0;
        dat_oe    = 1'b0;
        in_dat    = '0;
        in_vld    = 1'b0;
        out_rdy   = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        // Random transfers in a window around the top of the array
        // Wraps and overlaps are frequent
        // Upper address bits are noise
        for (int t = 0; t < N_XFER; t++) begin
            dir  = $urandom_range(0, 1);
            addr = ($urandom & 32'hFFFF_FC00)
                   | ((dram_pkg::MEM_DEPTH - 16 + $urandom_range(0, 31))
                      % dram_pkg::MEM_DEPTH);
            len  = $urandom_range(1, MAX_LEN);
            start_cmd(dir, addr);
            if (dir) begin
                write_burst(len);
            end else begin
                read_burst(len);
            end
            close_xfer();
        end

        // Directed wrap across the last word
        start_cmd(1'b1, 32'h0005_03FD);
        write_burst(6);
        close_xfer();
        // Nothing must land while dat_oe is low
        ignored_write(32'h0000_03FD);
        start_cmd(1'b0, 32'h0000_03FD);
        read_burst(6);
        close_xfer();
        // Wrapped words sit at word 0
        start_cmd(1'b0, 32'hA000_0000);
        read_burst(3);
        close_xfer();

        repeat (5) @(posedge clk);
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
